// ==== hw/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      dispatch,
  input  logic [ooo_pkg::XLEN-1:0]  a,
  input  logic [ooo_pkg::XLEN-1:0]  b,
  input  ooo_pkg::alu_op_e          op,
  input  logic [ooo_pkg::TAG_W-1:0] tag,
  output logic                      accept,
  output ooo_pkg::cdb_t             req,
  input  logic                      grant
);
  import ooo_pkg::*;

  logic [XLEN-1:0]  result;
  logic             valid_q;
  logic [TAG_W-1:0] tag_q;
  logic [XLEN-1:0]  value_q;

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLL: result = a << b[4:0];
      ALU_SLT: result = XLEN'($signed(a) < $signed(b));
      default: result = a;  // li
    endcase
  end

  assign accept = !valid_q || grant;  // free or leaving this cycle
  assign req    = '{valid: valid_q, tag: tag_q, value: value_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= dispatch;
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch) begin
      tag_q   <= tag;
      value_q <= result;
    end
  end

endmodule

`default_nettype wire

// ==== hw/cdb_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter (
  input  ooo_pkg::cdb_t mul_req,
  input  ooo_pkg::cdb_t alu_req,
  output logic          alu_grant,
  output ooo_pkg::cdb_t cdb
);

  // the multiplier has no result buffer, so it always goes first
  assign alu_grant = alu_req.valid && !mul_req.valid;

  always_comb begin
    if (mul_req.valid) begin
      cdb = mul_req;
    end else begin
      cdb = alu_req;  // invalid when idle
    end
  end

  // a tag lives in one unit at a time
  always_comb begin
    a_distinct_tags: assert final (!(mul_req.valid && alu_req.valid)
                                   || mul_req.tag != alu_req.tag);
  end

endmodule

`default_nettype wire

// ==== hw/issue_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_unit (
  input  ooo_pkg::instr_t           instr,
  input  logic                      instr_valid,
  output logic                      instr_ready,
  input  ooo_pkg::operand_t         src1,
  input  ooo_pkg::operand_t         src2,
  output logic [3:0]                rs1,
  output logic [3:0]                rs2,
  output logic [ooo_pkg::TAG_W-1:0] fwd_tag1,
  output logic [ooo_pkg::TAG_W-1:0] fwd_tag2,
  input  ooo_pkg::operand_t         fwd1,
  input  ooo_pkg::operand_t         fwd2,
  input  ooo_pkg::cdb_t             cdb,
  input  logic                      rob_full,
  input  logic [ooo_pkg::TAG_W-1:0] alloc_tag,
  output logic                      alloc,
  output logic                      rename_valid,
  output logic [3:0]                rename_rd,
  output logic [ooo_pkg::TAG_W-1:0] rename_tag,
  input  logic                      alu_full,
  input  logic                      mul_full,
  output logic                      alu_load,
  output logic                      mul_load,
  output ooo_pkg::operand_t         entry_a,
  output ooo_pkg::operand_t         entry_b,
  output logic [2:0]                entry_op,
  output logic [ooo_pkg::TAG_W-1:0] entry_tag
);
  import ooo_pkg::*;

  logic     is_mul;
  logic     is_li;
  operand_t op1;
  operand_t op2;

  // register value, then ROB forward, then same-cycle bus
  function automatic operand_t resolve(operand_t rf, operand_t rob, cdb_t bus);
    operand_t res;
    res = rf;
    if (!rf.ready) begin
      if (rob.ready) begin
        res = rob;
      end else if (bus.valid && bus.tag == rf.tag) begin
        res.ready = 1'b1;
        res.value = bus.value;
      end
    end
    return res;
  endfunction

  assign rs1      = instr.rs1;
  assign rs2      = instr.rs2;
  assign fwd_tag1 = src1.tag;
  assign fwd_tag2 = src2.tag;
  assign op1      = resolve(src1, fwd1, cdb);
  assign op2      = resolve(src2, fwd2, cdb);

  assign is_mul      = (instr.unit == UNIT_MUL);
  assign is_li       = !is_mul && (alu_op_e'(instr.op) == ALU_LI);
  assign instr_ready = !rob_full && !(is_mul ? mul_full : alu_full);
  assign alloc       = instr_valid && instr_ready;

  assign rename_valid = alloc;
  assign rename_rd    = instr.rd;
  assign rename_tag   = alloc_tag;

  assign alu_load  = alloc && !is_mul;
  assign mul_load  = alloc && is_mul;
  assign entry_op  = instr.op;
  assign entry_tag = alloc_tag;

  // li carries its immediate and needs no sources
  assign entry_a = is_li ? '{ready: 1'b1, tag: alloc_tag,
                             value: {{(XLEN-16){instr.imm[15]}}, instr.imm}} : op1;
  assign entry_b = is_li ? '{ready: 1'b1, tag: alloc_tag, value: '0} : op2;

endmodule

`default_nettype wire

// ==== hw/mult_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module mult_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      dispatch,
  input  logic [ooo_pkg::XLEN-1:0]  a,
  input  logic [ooo_pkg::XLEN-1:0]  b,
  input  ooo_pkg::mul_op_e          op,
  input  logic [ooo_pkg::TAG_W-1:0] tag,
  output ooo_pkg::cdb_t             req
);
  import ooo_pkg::*;

  logic                     s1_valid;
  logic [XLEN-1:0]          s1_a;
  logic [XLEN-1:0]          s1_b;
  mul_op_e                  s1_op;
  logic [TAG_W-1:0]         s1_tag;
  logic                     s2_valid;
  logic signed [2*XLEN-1:0] s2_prod;
  mul_op_e                  s2_op;
  logic [TAG_W-1:0]         s2_tag;
  logic                     s3_valid;
  logic [XLEN-1:0]          s3_value;
  logic [TAG_W-1:0]         s3_tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= dispatch;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_a     <= a;
    s1_b     <= b;
    s1_op    <= op;
    s1_tag   <= tag;
    s2_prod  <= $signed(s1_a) * $signed(s1_b);  // full signed product
    s2_op    <= s1_op;
    s2_tag   <= s1_tag;
    s3_value <= (s2_op == MUL_MULH) ? s2_prod[2*XLEN-1:XLEN] : s2_prod[XLEN-1:0];
    s3_tag   <= s2_tag;
  end

  assign req = '{valid: s3_valid, tag: s3_tag, value: s3_value};

endmodule

`default_nettype wire

// ==== hw/ooo_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module ooo_core #(
  parameter int RS_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  ooo_pkg::instr_t   instr,
  input  logic              instr_valid,
  output logic              instr_ready,
  output ooo_pkg::commit_t  commit
);
  import ooo_pkg::*;

  operand_t         src1, src2, fwd1, fwd2, entry_a, entry_b;
  logic [3:0]       rs1, rs2, rename_rd;
  logic [TAG_W-1:0] fwd_tag1, fwd_tag2, alloc_tag, rename_tag, entry_tag, commit_tag;
  logic             rob_full, alloc, rename_valid;
  logic             alu_full, mul_full, alu_load, mul_load;
  logic [2:0]       entry_op;
  cdb_t             cdb, alu_req, mul_req;
  logic             alu_dispatch, mul_dispatch, alu_accept, alu_grant;
  logic [XLEN-1:0]  alu_a, alu_b, mul_a, mul_b;
  alu_op_e          alu_op;
  mul_op_e          mul_op;
  logic [TAG_W-1:0] alu_tag, mul_tag;

  register_file u_regs (
    .clk, .rst, .rs1, .rs2, .src1, .src2,
    .rename_valid, .rename_rd, .rename_tag, .commit, .commit_tag
  );

  issue_unit u_issue (
    .instr, .instr_valid, .instr_ready, .src1, .src2, .rs1, .rs2,
    .fwd_tag1, .fwd_tag2, .fwd1, .fwd2, .cdb, .rob_full, .alloc_tag, .alloc,
    .rename_valid, .rename_rd, .rename_tag, .alu_full, .mul_full,
    .alu_load, .mul_load, .entry_a, .entry_b, .entry_op, .entry_tag
  );

  // ****************************************
  // stations and execution units
  // ****************************************
  reservation_station #(.RS_DEPTH(RS_DEPTH), .op_t(alu_op_e)) u_alu_rs (
    .clk, .rst, .load(alu_load), .entry_a, .entry_b, .entry_op(alu_op_e'(entry_op)),
    .entry_tag, .full(alu_full), .cdb, .accept(alu_accept), .dispatch(alu_dispatch),
    .out_a(alu_a), .out_b(alu_b), .out_op(alu_op), .out_tag(alu_tag)
  );

  reservation_station #(.RS_DEPTH(RS_DEPTH), .op_t(mul_op_e)) u_mul_rs (
    .clk, .rst, .load(mul_load), .entry_a, .entry_b, .entry_op(mul_op_e'(entry_op[0])),
    .entry_tag, .full(mul_full), .cdb, .accept(1'b1), .dispatch(mul_dispatch),
    .out_a(mul_a), .out_b(mul_b), .out_op(mul_op), .out_tag(mul_tag)
  );

  alu_unit u_alu (
    .clk, .rst, .dispatch(alu_dispatch), .a(alu_a), .b(alu_b), .op(alu_op),
    .tag(alu_tag), .accept(alu_accept), .req(alu_req), .grant(alu_grant)
  );

  mult_unit u_mul (
    .clk, .rst, .dispatch(mul_dispatch), .a(mul_a), .b(mul_b), .op(mul_op),
    .tag(mul_tag), .req(mul_req)
  );

  cdb_arbiter u_arb (.mul_req, .alu_req, .alu_grant, .cdb);

  reorder_buffer u_rob (
    .clk, .rst, .alloc, .alloc_rd(rename_rd), .alloc_tag, .full(rob_full),
    .fwd_tag1, .fwd_tag2, .fwd1, .fwd2, .cdb, .commit, .commit_tag
  );

endmodule

`default_nettype wire

// ==== hw/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

  localparam int XLEN      = 32;
  localparam int ROB_DEPTH = 8;
  localparam int TAG_W     = $clog2(ROB_DEPTH);

  typedef enum logic {
    UNIT_ALU,
    UNIT_MUL
  } unit_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SLT,
    ALU_LI
  } alu_op_e;

  typedef enum logic {
    MUL_MUL,   // low word
    MUL_MULH   // high word
  } mul_op_e;

  typedef struct packed {
    unit_e       unit;
    logic [2:0]  op;    // alu_op_e or mul_op_e by unit
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [15:0] imm;   // li only
  } instr_t;

  typedef struct packed {
    logic             ready;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  value;
  } operand_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  value;
  } cdb_t;

  typedef struct packed {
    logic            valid;
    logic [3:0]      rd;
    logic [XLEN-1:0] value;
  } commit_t;

endpackage

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [3:0]                rs1,
  input  logic [3:0]                rs2,
  output ooo_pkg::operand_t         src1,
  output ooo_pkg::operand_t         src2,
  input  logic                      rename_valid,
  input  logic [3:0]                rename_rd,
  input  logic [ooo_pkg::TAG_W-1:0] rename_tag,
  input  ooo_pkg::commit_t          commit,
  input  logic [ooo_pkg::TAG_W-1:0] commit_tag
);
  import ooo_pkg::*;

  logic [XLEN-1:0]  regs     [16];
  logic [TAG_W-1:0] pend_tag [16];
  logic [15:0]      busy;

  assign src1 = '{ready: !busy[rs1], tag: pend_tag[rs1], value: regs[rs1]};
  assign src2 = '{ready: !busy[rs2], tag: pend_tag[rs2], value: regs[rs2]};

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (commit.valid) begin
        regs[commit.rd] <= commit.value;
        if (pend_tag[commit.rd] == commit_tag) begin
          busy[commit.rd] <= 1'b0;  // only the latest writer frees it
        end
      end
      if (rename_valid) begin
        busy[rename_rd] <= 1'b1;    // rename wins over commit
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rename_valid) begin
      pend_tag[rename_rd] <= rename_tag;
    end
  end

  a_no_rename_in_reset: assert property (@(posedge clk) rst |-> !rename_valid);

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      alloc,
  input  logic [3:0]                alloc_rd,
  output logic [ooo_pkg::TAG_W-1:0] alloc_tag,
  output logic                      full,
  input  logic [ooo_pkg::TAG_W-1:0] fwd_tag1,
  input  logic [ooo_pkg::TAG_W-1:0] fwd_tag2,
  output ooo_pkg::operand_t         fwd1,
  output ooo_pkg::operand_t         fwd2,
  input  ooo_pkg::cdb_t             cdb,
  output ooo_pkg::commit_t          commit,
  output logic [ooo_pkg::TAG_W-1:0] commit_tag
);
  import ooo_pkg::*;

  logic [3:0]       rd_q    [ROB_DEPTH];
  logic [XLEN-1:0]  value_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done;
  logic [TAG_W-1:0] head;
  logic [TAG_W-1:0] tail;
  logic [TAG_W:0]   count;
  logic             commit_fire;
  logic [TAG_W-1:0] cdb_dist;

  assign alloc_tag   = tail;
  assign full        = (count == (TAG_W+1)'(ROB_DEPTH));
  assign commit_fire = (count != '0) && done[head];
  assign commit_tag  = head;
  assign commit      = '{valid: commit_fire, rd: rd_q[head], value: value_q[head]};

  // a pending tag always names a live entry
  assign fwd1 = '{ready: done[fwd_tag1], tag: fwd_tag1, value: value_q[fwd_tag1]};
  assign fwd2 = '{ready: done[fwd_tag2], tag: fwd_tag2, value: value_q[fwd_tag2]};

  // ****************************************
  // pointers and done flags
  // ****************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else begin
      if (alloc) begin
        tail       <= tail + 1'b1;
        done[tail] <= 1'b0;
      end
      if (cdb.valid) begin
        done[cdb.tag] <= 1'b1;
      end
      if (commit_fire) begin
        head <= head + 1'b1;
      end
      count <= count + (TAG_W+1)'(alloc) - (TAG_W+1)'(commit_fire);
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      rd_q[tail] <= alloc_rd;
    end
    if (cdb.valid) begin
      value_q[cdb.tag] <= cdb.value;
    end
  end

  // ****************************************
  // checks
  // ****************************************
  assign cdb_dist = cdb.tag - head;  // age of the broadcast entry

  a_no_alloc_when_full: assert property (@(posedge clk) disable iff (rst) alloc |-> !full);
  a_cdb_to_live_entry: assert property (@(posedge clk) disable iff (rst)
    cdb.valid |-> ({1'b0, cdb_dist} < count));

endmodule

`default_nettype wire

// ==== hw/reservation_station.sv ====
`timescale 1ns/100ps
`default_nettype none

module reservation_station #(
  parameter int  RS_DEPTH = 4,
  parameter type op_t     = logic [2:0]
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      load,
  input  ooo_pkg::operand_t         entry_a,
  input  ooo_pkg::operand_t         entry_b,
  input  op_t                       entry_op,
  input  logic [ooo_pkg::TAG_W-1:0] entry_tag,
  output logic                      full,
  input  ooo_pkg::cdb_t             cdb,
  input  logic                      accept,
  output logic                      dispatch,
  output logic [ooo_pkg::XLEN-1:0]  out_a,
  output logic [ooo_pkg::XLEN-1:0]  out_b,
  output op_t                       out_op,
  output logic [ooo_pkg::TAG_W-1:0] out_tag
);
  import ooo_pkg::*;

  localparam int CNT_W = $clog2(RS_DEPTH + 1);
  localparam int SEL_W = $clog2(RS_DEPTH);

  // slot 0 is the oldest, entries shift down as older ones leave
  operand_t         a_q   [RS_DEPTH];
  operand_t         b_q   [RS_DEPTH];
  op_t              op_q  [RS_DEPTH];
  logic [TAG_W-1:0] tag_q [RS_DEPTH];
  operand_t         a_n   [RS_DEPTH];
  operand_t         b_n   [RS_DEPTH];
  op_t              op_n  [RS_DEPTH];
  logic [TAG_W-1:0] tag_n [RS_DEPTH];
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] load_pos;
  logic [SEL_W-1:0] sel;
  logic             found;

  function automatic operand_t wake(operand_t src, cdb_t bus);
    operand_t res;
    res = src;
    if (!src.ready && bus.valid && bus.tag == src.tag) begin
      res.ready = 1'b1;
      res.value = bus.value;
    end
    return res;
  endfunction

  // ****************************************
  // oldest ready pick
  // ****************************************
  always_comb begin
    found = 1'b0;
    sel   = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (i < int'(count) && a_q[i].ready && b_q[i].ready) begin
        found = 1'b1;
        sel   = SEL_W'(i);
      end
    end
  end

  assign dispatch = found && accept;
  assign out_a    = a_q[sel].value;
  assign out_b    = b_q[sel].value;
  assign out_op   = op_q[sel];
  assign out_tag  = tag_q[sel];
  assign full     = (count == CNT_W'(RS_DEPTH));
  assign load_pos = count - CNT_W'(dispatch);

  // ****************************************
  // compaction, load and wakeup
  // ****************************************
  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      a_n[i]   = a_q[i];
      b_n[i]   = b_q[i];
      op_n[i]  = op_q[i];
      tag_n[i] = tag_q[i];
    end
    for (int i = 0; i < RS_DEPTH - 1; i++) begin
      if (dispatch && i >= int'(sel)) begin
        a_n[i]   = a_q[i+1];
        b_n[i]   = b_q[i+1];
        op_n[i]  = op_q[i+1];
        tag_n[i] = tag_q[i+1];
      end
    end
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (load && i == int'(load_pos)) begin
        a_n[i]   = entry_a;
        b_n[i]   = entry_b;
        op_n[i]  = entry_op;
        tag_n[i] = entry_tag;
      end
      a_n[i] = wake(a_n[i], cdb);
      b_n[i] = wake(b_n[i], cdb);
    end
  end

  always_ff @(posedge clk) begin
    a_q   <= a_n;
    b_q   <= b_n;
    op_q  <= op_n;
    tag_q <= tag_n;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      count <= count + CNT_W'(load) - CNT_W'(dispatch);
    end
  end

  a_no_load_when_full: assert property (@(posedge clk) disable iff (rst) load |-> !full);

endmodule

`default_nettype wire

// ==== ooo_core.f ====
hw/ooo_pkg.sv
hw/register_file.sv
hw/issue_unit.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/mult_unit.sv
hw/cdb_arbiter.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
verification/ooo_core_tb.sv

// ==== verification/ooo_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ooo_core_tb;
  import ooo_pkg::*;

  localparam int TOTAL_INSTR      = 243;  // sum over all tests
  localparam int CYCLES_PER_INSTR = 40;

  logic    clk;
  logic    rst;
  instr_t  instr;
  logic    instr_valid;
  logic    instr_ready;
  commit_t commit;

  logic [XLEN-1:0] model_regs [16];
  commit_t         exp_q [$];
  string           test_name;
  int              seed;
  bit              saw_stall;

  ooo_core #(.RS_DEPTH(4)) DUT (
    .clk, .rst, .instr, .instr_valid, .instr_ready, .commit
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // ****************************************
  // instruction builders and reference model
  // ****************************************
  function automatic instr_t alu_instr(alu_op_e op, logic [3:0] rd, logic [3:0] rs1,
                                       logic [3:0] rs2);
    instr_t ins;
    ins      = '0;
    ins.unit = UNIT_ALU;
    ins.op   = op;
    ins.rd   = rd;
    ins.rs1  = rs1;
    ins.rs2  = rs2;
    return ins;
  endfunction

  function automatic instr_t mul_instr(mul_op_e op, logic [3:0] rd, logic [3:0] rs1,
                                       logic [3:0] rs2);
    instr_t ins;
    ins      = '0;
    ins.unit = UNIT_MUL;
    ins.op   = {2'b00, op};
    ins.rd   = rd;
    ins.rs1  = rs1;
    ins.rs2  = rs2;
    return ins;
  endfunction

  function automatic instr_t li_instr(logic [3:0] rd, logic [15:0] imm);
    instr_t ins;
    ins      = alu_instr(ALU_LI, rd, 4'd0, 4'd0);
    ins.imm  = imm;
    return ins;
  endfunction

  function automatic logic [XLEN-1:0] expected_result(instr_t ins);
    logic [XLEN-1:0]          a;
    logic [XLEN-1:0]          b;
    logic signed [2*XLEN-1:0] prod;
    a = model_regs[ins.rs1];
    b = model_regs[ins.rs2];
    if (ins.unit == UNIT_MUL) begin
      prod = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
      return ins.op[0] ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];  // mulh takes high word
    end
    case (alu_op_e'(ins.op))
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return {{(XLEN-16){ins.imm[15]}}, ins.imm};
    endcase
  endfunction

  // starts and ends on a falling edge
  task automatic issue_instr(input instr_t ins);
    commit_t exp;
    bit      taken;
    exp.valid = 1'b1;
    exp.rd    = ins.rd;
    exp.value = expected_result(ins);
    model_regs[ins.rd] = exp.value;
    exp_q.push_back(exp);
    instr       = ins;
    instr_valid = 1'b1;
    taken       = 1'b0;
    while (!taken) begin
      #1;  // let the stall logic settle
      taken = instr_ready;
      if (!taken) begin
        saw_stall = 1'b1;
      end
      @(negedge clk);
    end
    instr_valid = 1'b0;
  endtask

  task automatic wait_for_commits();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // commit is driven from registers only
  always @(negedge clk) begin : check_commit
    commit_t exp;
    if (!rst && commit.valid) begin
      assert (exp_q.size() != 0)
        else stop_with_failure($sformatf("%s: commit to r%0d with no instruction outstanding",
                                         test_name, commit.rd));
      exp = exp_q.pop_front();
      assert (commit.rd == exp.rd && commit.value == exp.value)
        else stop_with_failure($sformatf("Mismatch in %s: expected r%0d = %h, actual r%0d = %h",
                                         test_name, exp.rd, exp.value, commit.rd, commit.value));
    end
  end

  initial begin
    repeat (10 + TOTAL_INSTR * CYCLES_PER_INSTR) @(posedge clk);
    stop_with_failure("Timeout: the instructions did not all commit in time");
  end

  // ****************************************
  // tests
  // ****************************************
  task automatic li_alu_basic();
    test_name = "li_alu_basic";
    issue_instr(li_instr(4'd1, 16'h1234));
    issue_instr(li_instr(4'd2, 16'hfffd));
    issue_instr(li_instr(4'd3, 16'd5));
    issue_instr(li_instr(4'd4, 16'h7fff));
    issue_instr(alu_instr(ALU_ADD, 4'd5, 4'd1, 4'd2));
    issue_instr(alu_instr(ALU_SUB, 4'd6, 4'd2, 4'd1));
    issue_instr(alu_instr(ALU_AND, 4'd7, 4'd1, 4'd4));
    issue_instr(alu_instr(ALU_OR, 4'd8, 4'd1, 4'd2));
    issue_instr(alu_instr(ALU_XOR, 4'd9, 4'd3, 4'd4));
    issue_instr(alu_instr(ALU_SLL, 4'd10, 4'd1, 4'd3));
    issue_instr(alu_instr(ALU_SLT, 4'd11, 4'd2, 4'd1));  // negative < positive
    issue_instr(alu_instr(ALU_SLT, 4'd12, 4'd1, 4'd2));
    wait_for_commits();
  endtask

  task automatic raw_chain();
    test_name = "raw_chain";
    issue_instr(li_instr(4'd1, 16'd7));
    issue_instr(li_instr(4'd2, 16'hfff7));
    issue_instr(mul_instr(MUL_MUL, 4'd3, 4'd1, 4'd2));
    issue_instr(alu_instr(ALU_ADD, 4'd4, 4'd3, 4'd1));
    issue_instr(mul_instr(MUL_MUL, 4'd5, 4'd4, 4'd4));
    issue_instr(mul_instr(MUL_MULH, 4'd6, 4'd5, 4'd2));
    issue_instr(alu_instr(ALU_SUB, 4'd7, 4'd6, 4'd5));
    issue_instr(alu_instr(ALU_SLL, 4'd8, 4'd7, 4'd1));
    issue_instr(mul_instr(MUL_MUL, 4'd9, 4'd8, 4'd8));
    issue_instr(mul_instr(MUL_MULH, 4'd10, 4'd9, 4'd9));
    issue_instr(alu_instr(ALU_XOR, 4'd11, 4'd10, 4'd9));
    wait_for_commits();
  endtask

  task automatic out_of_order_finish();
    test_name = "out_of_order_finish";
    issue_instr(li_instr(4'd1, 16'd1000));
    issue_instr(li_instr(4'd2, 16'd3));
    issue_instr(mul_instr(MUL_MUL, 4'd3, 4'd1, 4'd2));
    issue_instr(alu_instr(ALU_ADD, 4'd4, 4'd1, 4'd2));
    issue_instr(alu_instr(ALU_SUB, 4'd5, 4'd1, 4'd2));
    issue_instr(alu_instr(ALU_XOR, 4'd6, 4'd1, 4'd2));
    issue_instr(alu_instr(ALU_OR, 4'd7, 4'd2, 4'd1));
    issue_instr(alu_instr(ALU_AND, 4'd8, 4'd1, 4'd2));
    wait_for_commits();
  endtask

  task automatic back_pressure();
    test_name = "back_pressure";
    issue_instr(li_instr(4'd1, 16'd3));
    issue_instr(li_instr(4'd2, 16'hfffb));
    saw_stall = 1'b0;
    for (int i = 0; i < 10; i++) begin
      issue_instr(mul_instr((i == 9) ? MUL_MULH : MUL_MUL, 4'd1, 4'd1, 4'd2));  // serial chain
    end
    assert (saw_stall)
      else stop_with_failure("back_pressure: instr_ready never dropped while the core was full");
    wait_for_commits();
  endtask

  task automatic random_program();
    instr_t      ins;
    logic [31:0] r;
    test_name = "random_program";
    for (int n = 0; n < 200; n++) begin
      r        = $random(seed);
      ins.unit = unit_e'(r[0]);
      ins.op   = r[0] ? {2'b00, r[1]} : r[3:1];
      ins.rd   = r[7:4];
      ins.rs1  = r[11:8];
      ins.rs2  = r[15:12];
      ins.imm  = r[31:16];
      issue_instr(ins);
      if (($random(seed) & 3) == 0) begin
        @(negedge clk);  // idle cycle with instr_valid low
      end
    end
    wait_for_commits();
  endtask

  initial begin
    seed        = 32'h2162;
    saw_stall   = 1'b0;
    test_name   = "reset";
    rst         = 1'b1;
    instr       = '0;
    instr_valid = 1'b0;
    for (int i = 0; i < 16; i++) begin
      model_regs[i] = '0;
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;
    li_alu_basic();
    raw_chain();
    out_of_order_finish();
    back_pressure();
    random_program();
    repeat (10) @(negedge clk);  // catch stray commits
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
